/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int COND_W   = 4;
    localparam int SEL_W    = 2;

    // pc source select
    localparam logic [SEL_W-1:0] SEL_PC_INC    = 2'b00;
    localparam logic [SEL_W-1:0] SEL_PC_START  = 2'b01;
    localparam logic [SEL_W-1:0] SEL_PC_BRANCH = 2'b11;

    // operand and shift source taken from the pc
    localparam logic [SEL_W-1:0] SEL_FROM_PC = 2'b11;

    // compare sets flags only, no destination write
    localparam logic [3:0] CMP_FUNC = 4'b1010;

    // load_pc_start sits above the cycle states
    typedef enum logic [3:0] {
        st_reset         = 4'd0,
        st_load_pc_start = 4'd8,
        st_fetch         = 4'd1,
        st_fetch_wait    = 4'd2,
        st_decode        = 4'd3,
        st_execute       = 4'd4,
        st_mem_inc_pc    = 4'd5,
        st_mem_wait      = 4'd6,
        st_write_back    = 4'd7
    } state_e;

    typedef enum logic [1:0] {
        cls_none,
        cls_alu,
        cls_mem,
        cls_branch
    } op_class_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_orr = 3'b011,
        alu_xor = 3'b111
    } alu_op_e;

    typedef enum logic [COND_W-1:0] {
        eq, ne, cs, cc, mi, pl, vs, vc,
        hi, ls, ge, lt, gt, le, al, nv
    } cond_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // pre-index, up, write-back
    typedef struct packed {
        logic p;
        logic u;
        logic w;
    } idx_t;

    typedef struct packed {
        logic w_en1;
        logic w_en2;
        logic w_en_ldr;
        logic sel_load_lr;
    } rf_ctrl_t;

    typedef struct packed {
        logic [SEL_W-1:0] sel_a_in;
        logic             en_a;
        logic             en_b;
        logic             en_s;
        logic             sel_shift;
        logic [SEL_W-1:0] sel_shift_in;
    } opnd_ctrl_t;

    typedef struct packed {
        logic    sel_a;
        logic    sel_b;
        logic    sel_branch_imme;
        logic    sel_post_indexing;
        alu_op_e alu_op;
    } exec_ctrl_t;

    typedef struct packed {
        logic en_status;
        logic status_rdy;
    } stat_ctrl_t;

    typedef struct packed {
        logic             load_ir;
        logic             load_pc;
        logic [SEL_W-1:0] sel_pc;
    } fetch_ctrl_t;

    typedef struct packed {
        logic ram_w_en;
    } mem_ctrl_t;

    typedef struct packed {
        op_class_e op_class;
        alu_op_e   alu_op;
        logic      uses_a;
        logic      uses_b;
        logic      shift_reg;
        logic      ldr_lit;
        logic      is_store;
        logic      link;
        logic      br_reg;
        logic      writes_rd;
        logic      ldr_wb;
    } dec_t;

endpackage

/* rtl/cpu_sequencer.sv */
`timescale 1ns/1ns

module cpu_sequencer
    import ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    output state_e state
);

    // fixed seven-state instruction loop, one state per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_reset;
        end else begin
            case (state)
                st_reset:         state <= st_load_pc_start;
                st_load_pc_start: state <= st_fetch;
                st_fetch:         state <= st_fetch_wait;
                st_fetch_wait:    state <= st_decode;
                st_decode:        state <= st_execute;
                st_execute:       state <= st_mem_inc_pc;
                st_mem_inc_pc:    state <= st_mem_wait;
                st_mem_wait:      state <= st_write_back;
                // back to fetch for the next instruction
                st_write_back:    state <= st_fetch;
                // unused codes recover through reset
                default:          state <= st_reset;
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {st_reset, st_load_pc_start, st_fetch, st_fetch_wait, st_decode,
                      st_execute, st_mem_inc_pc, st_mem_wait, st_write_back}
    ) else $error("sequencer left the legal state set");

endmodule

/* rtl/op_decode.sv */
`timescale 1ns/1ns

module op_decode
    import ctrl_pkg::*;
(
    input  logic [OPCODE_W-1:0] opcode,
    input  cond_e               cond,
    output dec_t                dec
);

    logic is_alu;
    logic is_mem;
    logic is_branch;

    // alu ops need bit 6 clear and a condition other than never
    assign is_alu    = (opcode[6] == 1'b0) && (cond != nv);
    // 11xxxxx and 1000xxx are loads and stores
    assign is_mem    = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
    assign is_branch = (opcode[6:3] == 4'b1001);

    always_comb begin
        if (is_alu) begin
            dec.op_class = cls_alu;
        end else if (is_mem) begin
            dec.op_class = cls_mem;
        end else if (is_branch) begin
            dec.op_class = cls_branch;
        end else begin
            dec.op_class = cls_none;
        end
    end

    // function code in the low three bits
    always_comb begin
        dec.alu_op = alu_add;
        if (is_alu) begin
            case (opcode[2:0])
                3'b000:  dec.alu_op = alu_add;
                3'b001:  dec.alu_op = alu_sub;
                3'b010:  dec.alu_op = alu_sub;
                3'b011:  dec.alu_op = alu_and;
                3'b100:  dec.alu_op = alu_orr;
                3'b101:  dec.alu_op = alu_xor;
                default: dec.alu_op = alu_add;
            endcase
        end
    end

    // register operands
    assign dec.uses_a    = opcode[3];
    assign dec.uses_b    = opcode[4];
    // shift amount from a register only with a register operand b
    assign dec.shift_reg = opcode[4] & opcode[5];

    // everything except cmp writes rd
    assign dec.writes_rd = is_alu && (opcode[3:0] != CMP_FUNC);

    // pc-relative load, immediate form of 100xxxx
    assign dec.ldr_lit   = (opcode[6:4] == 3'b100) && (opcode[3] == 1'b0);
    assign dec.is_store  = opcode[4];

    // branch with link and branch to register
    assign dec.link      = opcode[2];
    assign dec.br_reg    = opcode[1];

    // loaded data goes back to rd at write-back
    assign dec.ldr_wb    = (opcode[6:4] == 3'b110) || (opcode[6:3] == 4'b1000);

endmodule

/* rtl/cond_check.sv */
`timescale 1ns/1ns

module cond_check
    import ctrl_pkg::*;
(
    input  cond_e  cond,
    input  flags_t flags,
    output logic   taken
);

    logic n_eq_v;

    // signed comparisons all hinge on n == v
    assign n_eq_v = (flags.n == flags.v);

    always_comb begin
        taken = 1'b0;
        case (cond)
            eq: taken = flags.z;
            ne: taken = ~flags.z;
            cs: taken = flags.c;
            cc: taken = ~flags.c;
            mi: taken = flags.n;
            pl: taken = ~flags.n;
            vs: taken = flags.v;
            vc: taken = ~flags.v;
            // unsigned higher / lower or same
            hi: taken = flags.c & ~flags.z;
            ls: taken = ~flags.c | flags.z;
            // signed
            ge: taken = n_eq_v;
            lt: taken = ~n_eq_v;
            gt: taken = ~flags.z & n_eq_v;
            le: taken = flags.z | ~n_eq_v;
            al: taken = 1'b1;
            nv: taken = 1'b0;
        endcase
    end

endmodule

/* rtl/stage_ctrl.sv */
`timescale 1ns/1ns

module stage_ctrl
    import ctrl_pkg::*;
(
    input  state_e      state,
    input  dec_t        dec,
    input  logic        taken,
    input  idx_t        idx,
    input  logic        en_status_decode,
    output rf_ctrl_t    rf,
    output opnd_ctrl_t  opnd,
    output exec_ctrl_t  exec,
    output stat_ctrl_t  stat,
    output fetch_ctrl_t fetch,
    output mem_ctrl_t   mem
);

    always_comb begin
        // idle strobes unless the state asks for something
        rf    = '0;
        opnd  = '0;
        exec  = '0;
        stat  = '0;
        fetch = '0;
        mem   = '0;

        case (state)
            st_load_pc_start: begin
                fetch.load_pc = 1'b1;
                fetch.sel_pc  = SEL_PC_START;
            end

            st_decode: begin
                fetch.load_ir = 1'b1;
            end

            // operand stage loads
            st_execute: begin
                case (dec.op_class)
                    cls_alu: begin
                        opnd.en_a      = dec.uses_a;
                        opnd.en_b      = dec.uses_b;
                        opnd.en_s      = 1'b1;
                        opnd.sel_shift = dec.shift_reg;
                    end
                    cls_mem: begin
                        if (!dec.uses_a) begin
                            // immediate offset, base from rn or pc
                            opnd.en_a = 1'b1;
                            if (dec.ldr_lit) begin
                                opnd.sel_a_in = SEL_FROM_PC;
                            end
                        end else begin
                            opnd.en_a = 1'b1;
                            opnd.en_b = 1'b1;
                            opnd.en_s = 1'b1;
                        end
                    end
                    cls_branch: begin
                        opnd.en_b         = dec.br_reg;
                        opnd.en_s         = 1'b1;
                        opnd.sel_shift    = 1'b1;
                        opnd.sel_shift_in = SEL_FROM_PC;
                    end
                    default: begin
                    end
                endcase
            end

            // alu, memory access and pc update in the same cycle
            st_mem_inc_pc: begin
                case (dec.op_class)
                    cls_alu: begin
                        fetch.load_pc  = 1'b1;
                        fetch.sel_pc   = SEL_PC_INC;
                        exec.alu_op    = dec.alu_op;
                        // immediate paths when no register operand
                        exec.sel_a     = ~dec.uses_a;
                        exec.sel_b     = ~dec.uses_b;
                        stat.en_status = en_status_decode;
                        rf.w_en1       = dec.writes_rd;
                    end
                    cls_mem: begin
                        fetch.load_pc          = 1'b1;
                        fetch.sel_pc           = SEL_PC_INC;
                        exec.alu_op            = idx.u ? alu_add : alu_sub;
                        exec.sel_b             = ~dec.uses_a;
                        exec.sel_post_indexing = ~idx.p;
                        stat.en_status         = en_status_decode;
                        // base update on post-index or explicit writeback
                        rf.w_en2               = ~idx.p | idx.w;
                        mem.ram_w_en           = dec.is_store;
                    end
                    cls_branch: begin
                        fetch.load_pc        = 1'b1;
                        fetch.sel_pc         = taken ? SEL_PC_BRANCH : SEL_PC_INC;
                        rf.w_en1             = dec.link;
                        // target is pc plus offset
                        exec.alu_op          = alu_add;
                        exec.sel_a           = 1'b1;
                        exec.sel_b           = ~dec.br_reg;
                        exec.sel_branch_imme = ~dec.br_reg;
                    end
                    default: begin
                    end
                endcase
            end

            st_mem_wait: begin
                stat.status_rdy = 1'b1;
            end

            st_write_back: begin
                rf.w_en_ldr = dec.ldr_wb;
            end

            default: begin
            end
        endcase
    end

endmodule

/* rtl/controller_top.sv */
`timescale 1ns/1ns

module controller_top
    import ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [OPCODE_W-1:0] opcode,
    input  cond_e               cond,
    input  flags_t              flags,
    input  idx_t                idx,
    input  logic                en_status_decode,
    output rf_ctrl_t            rf,
    output opnd_ctrl_t          opnd,
    output exec_ctrl_t          exec,
    output stat_ctrl_t          stat,
    output fetch_ctrl_t         fetch,
    output mem_ctrl_t           mem
);

    state_e state;
    dec_t   dec;
    logic   taken;

    cpu_sequencer u_cpu_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state)
    );

    op_decode u_op_decode (
        .opcode (opcode),
        .cond   (cond),
        .dec    (dec)
    );

    cond_check u_cond_check (
        .cond  (cond),
        .flags (flags),
        .taken (taken)
    );

    stage_ctrl u_stage_ctrl (
        .state            (state),
        .dec              (dec),
        .taken            (taken),
        .idx              (idx),
        .en_status_decode (en_status_decode),
        .rf               (rf),
        .opnd             (opnd),
        .exec             (exec),
        .stat             (stat),
        .fetch            (fetch),
        .mem              (mem)
    );

endmodule

/* test/controller_tb.sv */
`timescale 1ns/1ns

module controller_tb
    import ctrl_pkg::*;
;

    localparam int WAIT_LIMIT = 20;

    logic                clk;
    logic                rst_n;
    logic [OPCODE_W-1:0] opcode;
    cond_e               cond;
    flags_t              flags;
    idx_t                idx;
    logic                en_status_decode;
    rf_ctrl_t            rf;
    opnd_ctrl_t          opnd;
    exec_ctrl_t          exec;
    stat_ctrl_t          stat;
    fetch_ctrl_t         fetch;
    mem_ctrl_t           mem;

    // outputs seen in execute, mem/pc increment, mem wait and write-back
    rf_ctrl_t    rf_cap    [1:4];
    opnd_ctrl_t  opnd_cap  [1:4];
    exec_ctrl_t  exec_cap  [1:4];
    stat_ctrl_t  stat_cap  [1:4];
    fetch_ctrl_t fetch_cap [1:4];
    mem_ctrl_t   mem_cap   [1:4];

    logic [31:0] seed;

    controller_top u_controller_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .opcode           (opcode),
        .cond             (cond),
        .flags            (flags),
        .idx              (idx),
        .en_status_decode (en_status_decode),
        .rf               (rf),
        .opnd             (opnd),
        .exec             (exec),
        .stat             (stat),
        .fetch            (fetch),
        .mem              (mem)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference branch table
    function automatic logic cond_holds(input cond_e c, input flags_t f);
        case (c)
            eq: return f.z;
            ne: return !f.z;
            cs: return f.c;
            cc: return !f.c;
            mi: return f.n;
            pl: return !f.n;
            vs: return f.v;
            vc: return !f.v;
            hi: return f.c && !f.z;
            ls: return !f.c || f.z;
            ge: return f.n == f.v;
            lt: return f.n != f.v;
            gt: return !f.z && (f.n == f.v);
            le: return f.z || (f.n != f.v);
            al: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [2:0] expected_alu_op(input logic [2:0] func);
        case (func)
            3'b000: return 3'b000;
            3'b001: return 3'b001;
            3'b010: return 3'b001;
            3'b011: return 3'b010;
            3'b100: return 3'b011;
            3'b101: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    task automatic check(input string name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0h actual %0h", name, field, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic wait_load_ir(input string name, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (fetch.load_ir) begin
                seen = 1'b1;
            end else if (cycles >= WAIT_LIMIT) begin
                $display("%s: load_ir never came within %0d cycles", name, WAIT_LIMIT);
                $display("Test failed");
                $fatal(1);
            end
        end
    endtask

    // drive one instruction and capture the four stages after decode
    task automatic run_instr(input string name, input logic [6:0] op, input cond_e c,
                             input flags_t f, input idx_t ix, input logic en);
        int n;
        opcode           = op;
        cond             = c;
        flags            = f;
        idx              = ix;
        en_status_decode = en;
        wait_load_ir(name, n);
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            rf_cap[k]    = rf;
            opnd_cap[k]  = opnd;
            exec_cap[k]  = exec;
            stat_cap[k]  = stat;
            fetch_cap[k] = fetch;
            mem_cap[k]   = mem;
        end
    endtask

    task automatic test_reset_startup();
        int n;
        repeat (5) begin
            @(negedge clk);
            check("reset", "outputs", 32'd0, {rf, opnd, exec, stat, fetch, mem});
        end
        rst_n = 1'b1;
        @(negedge clk);
        check("startup", "load_pc", 32'd1, fetch.load_pc);
        check("startup", "sel_pc", 32'd1, fetch.sel_pc);
        check("startup", "load_ir", 32'd0, fetch.load_ir);
        // fetch and fetch wait lie between start load and decode
        wait_load_ir("startup", n);
        check("startup", "cycles to load_ir", 32'd3, n);
        repeat (3) begin
            for (int k = 1; k <= 7; k++) begin
                @(negedge clk);
                check("startup", "status_rdy", (k == 3), stat.status_rdy);
                check("startup", "load_ir", (k == 7), fetch.load_ir);
            end
        end
    endtask

    task automatic test_alu();
        logic [6:0] op;
        logic       en;
        for (int hi = 0; hi < 8; hi++) begin
            for (int func = 0; func < 8; func++) begin
                op   = {1'b0, hi[2:0], func[2:0]};
                seed = lcg_step(seed);
                en   = seed[16];
                run_instr("alu", op, al, 4'b0000, 3'b000, en);
                check("alu", "en_a", op[3], opnd_cap[1].en_a);
                check("alu", "en_b", op[4], opnd_cap[1].en_b);
                check("alu", "en_s", 32'd1, opnd_cap[1].en_s);
                check("alu", "sel_shift", op[4] & op[5], opnd_cap[1].sel_shift);
                check("alu", "alu_op", expected_alu_op(op[2:0]), exec_cap[2].alu_op);
                check("alu", "sel_a", !op[3], exec_cap[2].sel_a);
                check("alu", "sel_b", !op[4], exec_cap[2].sel_b);
                check("alu", "w_en1", op[3:0] != 4'b1010, rf_cap[2].w_en1);
                check("alu", "en_status", en, stat_cap[2].en_status);
                check("alu", "load_pc", 32'd1, fetch_cap[2].load_pc);
                check("alu", "sel_pc", 32'd0, fetch_cap[2].sel_pc);
            end
        end
    endtask

    task automatic test_load_store();
        logic [6:0] op;
        idx_t       ix;
        logic       st;
        logic       reg_form;
        logic       lit;
        for (int i = 0; i < 8; i++) begin
            for (int form = 0; form < 5; form++) begin
                ix       = i[2:0];
                st       = (form == 2) || (form == 3);
                reg_form = (form == 1) || (form == 3);
                lit      = (form == 4);
                // store flag in bit 4, register offset in bit 3
                op       = lit ? 7'b1000000 : {2'b11, st, reg_form, 3'b000};
                run_instr("load_store", op, al, 4'b0000, ix, 1'b1);
                check("load_store", "en_a", 32'd1, opnd_cap[1].en_a);
                check("load_store", "en_b", reg_form, opnd_cap[1].en_b);
                check("load_store", "en_s", reg_form, opnd_cap[1].en_s);
                check("load_store", "sel_a_in", lit ? 32'd3 : 32'd0, opnd_cap[1].sel_a_in);
                check("load_store", "alu_op", ix.u ? 32'd0 : 32'd1, exec_cap[2].alu_op);
                check("load_store", "sel_b", !reg_form, exec_cap[2].sel_b);
                check("load_store", "sel_post_indexing", !ix.p,
                      exec_cap[2].sel_post_indexing);
                check("load_store", "w_en2", !ix.p || ix.w, rf_cap[2].w_en2);
                check("load_store", "ram_w_en", st, mem_cap[2].ram_w_en);
                check("load_store", "ram_w_en exec", 32'd0, mem_cap[1].ram_w_en);
                check("load_store", "ram_w_en wb", 32'd0, mem_cap[4].ram_w_en);
                check("load_store", "en_status", 32'd1, stat_cap[2].en_status);
                check("load_store", "sel_pc", 32'd0, fetch_cap[2].sel_pc);
                check("load_store", "w_en_ldr", !st, rf_cap[4].w_en_ldr);
            end
        end
    endtask

    task automatic test_branch();
        logic [6:0] op;
        flags_t     f;
        cond_e      c;
        for (int ci = 0; ci < 16; ci++) begin
            repeat (4) begin
                seed = lcg_step(seed);
                f    = seed[19:16];
                c    = cond_e'(ci[3:0]);
                op   = {4'b1001, seed[24], seed[25], seed[26]};
                run_instr("branch", op, c, f, 3'b000, 1'b0);
                check("branch", "sel_pc", cond_holds(c, f) ? 32'd3 : 32'd0,
                      fetch_cap[2].sel_pc);
                check("branch", "load_pc", 32'd1, fetch_cap[2].load_pc);
                check("branch", "w_en1", op[2], rf_cap[2].w_en1);
                check("branch", "sel_branch_imme", !op[1], exec_cap[2].sel_branch_imme);
                check("branch", "sel_a", 32'd1, exec_cap[2].sel_a);
                check("branch", "en_b", op[1], opnd_cap[1].en_b);
                check("branch", "sel_shift_in", 32'd3, opnd_cap[1].sel_shift_in);
            end
        end
    endtask

    task automatic check_idle(input string name);
        for (int k = 1; k <= 4; k++) begin
            if (k != 3) begin
                check(name, "rf", 32'd0, rf_cap[k]);
                check(name, "load_pc", 32'd0, fetch_cap[k].load_pc);
                check(name, "en_status", 32'd0, stat_cap[k].en_status);
                check(name, "ram_w_en", 32'd0, mem_cap[k].ram_w_en);
            end
        end
        check(name, "opnd", 32'd0, opnd_cap[1]);
    endtask

    task automatic test_inactive();
        run_instr("class_none", 7'b1010101, al, 4'b1111, 3'b111, 1'b1);
        check_idle("class_none");
        run_instr("alu_never", 7'b0011000, nv, 4'b1111, 3'b111, 1'b1);
        check_idle("alu_never");
    endtask

    initial begin
        rst_n            = 1'b0;
        opcode           = 7'b1010101;
        cond             = al;
        flags            = '0;
        idx              = '0;
        en_status_decode = 1'b0;
        seed             = 32'he382d5b0;

        test_reset_startup();
        test_alu();
        test_load_store();
        test_branch();
        test_inactive();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sources.f */
rtl/ctrl_pkg.sv
rtl/cpu_sequencer.sv
rtl/op_decode.sv
rtl/cond_check.sv
rtl/stage_ctrl.sv
rtl/controller_top.sv
test/controller_tb.sv
